/* Makefile */
VERILATOR ?= verilator
TOP ?= l1i_fetch_tb
FILELIST ?= l1i_fetch.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator runs from the project root so the trace path resolves
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* l1i_fetch.f */
source/l1i_geometry_pkg.sv
source/insn_class_pkg.sv
source/predecoder.sv
source/icache_arrays.sv
source/fetch_queue.sv
source/fetch_control.sv
source/l1i_fetch.sv
testbench/l1i_fetch_tb.sv

/* source/fetch_control.sv */
`timescale 1ns/10ps

module fetch_control
(
   input  logic clk,
   input  logic reset,
   input  logic restart_valid,
   input  l1i_geometry_pkg::addr_t restart_pc,
   output logic restart_ack,
   input  logic flush_req,
   output logic flush_complete,
   output logic mem_req_valid,
   output l1i_geometry_pkg::addr_t mem_req_addr,
   input  logic mem_rsp_valid,
   output l1i_geometry_pkg::set_idx_t lookup_idx,
   input  l1i_geometry_pkg::tag_t rd_tag,
   input  logic rd_valid,
   input  l1i_geometry_pkg::line_t rd_line,
   input  insn_class_pkg::pd_line_t rd_pd,
   output logic inval_valid,
   output l1i_geometry_pkg::set_idx_t inval_idx,
   input  logic fq_full,
   output logic fq_clear,
   output logic fq_push,
   output insn_class_pkg::insn_word_t push_data,
   output l1i_geometry_pkg::addr_t push_pc,
   output l1i_geometry_pkg::addr_t push_target,
   output logic push_taken
);
   import l1i_geometry_pkg::*;
   import insn_class_pkg::*;

   fetch_state_t state, n_state;
   // pc is the next lookup, cache_pc the lookup whose data is back now
   addr_t pc, n_pc;
   addr_t cache_pc, n_cache_pc;
   addr_t miss_pc, n_miss_pc;
   addr_t restart_pc_q, restart_target, jump_target;
   set_idx_t flush_idx;
   word_sel_t word_sel;
   pd_class_t pd;
   logic req, n_req, hit, serve;
   logic restart_held, flush_held, restart_pend, flush_pend;
   logic take_restart, take_flush, walk_done, mem_req_next;

   assign restart_pend = restart_valid || restart_held;
   assign flush_pend = flush_req || flush_held;
   assign restart_target = restart_valid ? restart_pc : restart_pc_q;

   // requests wait out the flush walk and any open reload
   assign serve = (state != FLUSH_CACHE) && (state != INJECT_RELOAD);
   assign take_flush = serve && flush_pend;
   assign take_restart = serve && restart_pend && !flush_pend;

   assign inval_valid = (state == FLUSH_CACHE);
   assign inval_idx = flush_idx;
   assign walk_done = inval_valid && (flush_idx == set_idx_t'(NUM_SETS - 1));

   // word at the cache pc
   assign word_sel = cache_pc[LG_LINE_BYTES-1:2];
   assign pd = rd_pd[word_sel];
   assign push_data = rd_line[word_sel*32 +: 32];
   assign push_pc = cache_pc;
   assign hit = req && rd_valid && (rd_tag == cache_pc[ADDR_WIDTH-1 -: TAG_BITS]);

   // J-type immediate, only j and jal are taken
   assign jump_target = cache_pc + {{11{push_data[31]}}, push_data[31], push_data[19:12],
                                    push_data[20], push_data[30:21], 1'b0};
   assign push_taken = (pd == PD_J) || (pd == PD_JAL);
   assign push_target = push_taken ? jump_target : cache_pc + 'd4;

   always_comb
   begin
      n_state = state;
      n_pc = pc;
      n_cache_pc = cache_pc;
      n_miss_pc = miss_pc;
      n_req = 1'b0;
      mem_req_next = 1'b0;
      fq_push = 1'b0;
      fq_clear = take_flush || take_restart;
      lookup_idx = pc[LG_LINE_BYTES +: LG_NUM_SETS];
      if (take_flush)
      begin
         n_state = FLUSH_CACHE;
      end
      else if (take_restart)
      begin
         n_state = ACTIVE;
         n_pc = restart_target;
      end
      else
      begin
         case (state)
            ACTIVE:
            begin
               n_cache_pc = pc;
               n_pc = pc + 'd4;
               n_req = 1'b1;
               if (req && (!hit || fq_full))
               begin
                  // park on this pc until the line arrives or the queue drains
                  n_state = hit ? WAIT_FOR_NOT_FULL : INJECT_RELOAD;
                  mem_req_next = !hit;
                  n_miss_pc = cache_pc;
                  n_pc = pc;
                  n_req = 1'b0;
               end
               else if (hit)
               begin
                  fq_push = 1'b1;
                  if (push_taken)
                  begin
                     // sequential lookup is dropped, target goes out next cycle
                     n_pc = jump_target;
                     n_req = 1'b0;
                  end
               end
            end
            INJECT_RELOAD:
            begin
               if (mem_rsp_valid)
                  n_state = RELOAD_TURNAROUND;
            end
            RELOAD_TURNAROUND, WAIT_FOR_NOT_FULL:
            begin
               lookup_idx = miss_pc[LG_LINE_BYTES +: LG_NUM_SETS];
               if (!fq_full)
               begin
                  n_state = ACTIVE;
                  n_cache_pc = miss_pc;
                  n_req = 1'b1;
               end
            end
            FLUSH_CACHE:
            begin
               if (walk_done)
                  n_state = IDLE;
            end
            default:
            begin
               // idle until a restart or flush is taken above
               n_state = IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= FLUSH_CACHE;
         flush_idx <= '0;
         req <= 1'b0;
         restart_held <= 1'b0;
         flush_held <= 1'b0;
         restart_ack <= 1'b0;
         flush_complete <= 1'b0;
         mem_req_valid <= 1'b0;
      end
      else
      begin
         state <= n_state;
         flush_idx <= inval_valid ? flush_idx + 1'b1 : '0;
         req <= n_req;
         restart_held <= restart_pend && !take_restart;
         flush_held <= flush_pend && !take_flush;
         restart_ack <= take_restart;
         flush_complete <= walk_done;
         mem_req_valid <= mem_req_next;
      end
   end

   always_ff @(posedge clk)
   begin
      pc <= n_pc;
      cache_pc <= n_cache_pc;
      miss_pc <= n_miss_pc;
      if (restart_valid)
         restart_pc_q <= restart_pc;
      // held until the fill that answers it
      if (mem_req_next)
         mem_req_addr <= {cache_pc[ADDR_WIDTH-1:LG_LINE_BYTES], {LG_LINE_BYTES{1'b0}}};
   end

endmodule

/* source/fetch_queue.sv */
`timescale 1ns/10ps

module fetch_queue
(
   input  logic clk,
   input  logic reset,
   input  logic clear,
   input  logic push,
   input  insn_class_pkg::insn_word_t push_data,
   input  l1i_geometry_pkg::addr_t push_pc,
   input  l1i_geometry_pkg::addr_t push_target,
   input  logic push_taken,
   input  logic pop,
   output logic full,
   output logic head_valid,
   output insn_class_pkg::insn_word_t head_data,
   output l1i_geometry_pkg::addr_t head_pc,
   output l1i_geometry_pkg::addr_t head_target,
   output logic head_taken
);
   import l1i_geometry_pkg::*;
   import insn_class_pkg::*;

   insn_word_t data_q [FQ_ENTRIES];
   addr_t pc_q [FQ_ENTRIES];
   addr_t target_q [FQ_ENTRIES];
   logic [FQ_ENTRIES-1:0] taken_q;
   fq_ptr_t head;
   fq_ptr_t tail;
   logic [LG_FQ_ENTRIES-1:0] head_slot;
   logic [LG_FQ_ENTRIES-1:0] tail_slot;

   assign head_slot = head[LG_FQ_ENTRIES-1:0];
   assign tail_slot = tail[LG_FQ_ENTRIES-1:0];

   // same slot with different wrap bits means full
   assign head_valid = (head != tail);
   assign full = (head_slot == tail_slot) && (head[LG_FQ_ENTRIES] != tail[LG_FQ_ENTRIES]);

   assign head_data = data_q[head_slot];
   assign head_pc = pc_q[head_slot];
   assign head_target = target_q[head_slot];
   assign head_taken = taken_q[head_slot];

   always_ff @(posedge clk)
   begin
      if (reset || clear)
      begin
         head <= '0;
         tail <= '0;
      end
      else
      begin
         if (push)
            tail <= tail + 1'b1;
         // a pop on an empty queue is ignored
         if (pop && head_valid)
            head <= head + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         data_q[tail_slot] <= push_data;
         pc_q[tail_slot] <= push_pc;
         target_q[tail_slot] <= push_target;
         taken_q[tail_slot] <= push_taken;
      end
   end

endmodule

/* source/icache_arrays.sv */
`timescale 1ns/10ps

module icache_arrays
(
   input  logic clk,
   input  logic reset,
   input  l1i_geometry_pkg::set_idx_t rd_idx,
   input  logic fill_valid,
   input  l1i_geometry_pkg::addr_t fill_addr,
   input  l1i_geometry_pkg::line_t fill_line,
   input  insn_class_pkg::pd_line_t fill_pd,
   input  logic inval_valid,
   input  l1i_geometry_pkg::set_idx_t inval_idx,
   output l1i_geometry_pkg::tag_t rd_tag,
   output logic rd_valid,
   output l1i_geometry_pkg::line_t rd_line,
   output insn_class_pkg::pd_line_t rd_pd
);
   import l1i_geometry_pkg::*;
   import insn_class_pkg::*;

   tag_t tag_mem [NUM_SETS];
   line_t line_mem [NUM_SETS];
   pd_line_t pd_mem [NUM_SETS];
   logic [NUM_SETS-1:0] valid_bits;
   set_idx_t fill_idx;

   assign fill_idx = fill_addr[LG_LINE_BYTES +: LG_NUM_SETS];

   always_ff @(posedge clk)
   begin
      if (fill_valid)
      begin
         tag_mem[fill_idx] <= fill_addr[ADDR_WIDTH-1 -: TAG_BITS];
         line_mem[fill_idx] <= fill_line;
         pd_mem[fill_idx] <= fill_pd;
      end
   end

   // fill and flush never overlap, fill checked first anyway
   always_ff @(posedge clk)
   begin
      if (fill_valid)
         valid_bits[fill_idx] <= 1'b1;
      else if (inval_valid)
         valid_bits[inval_idx] <= 1'b0;
   end

   // one-cycle read of all four arrays
   always_ff @(posedge clk)
   begin
      rd_tag <= tag_mem[rd_idx];
      rd_line <= line_mem[rd_idx];
      rd_pd <= pd_mem[rd_idx];
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         rd_valid <= 1'b0;
      else
         rd_valid <= valid_bits[rd_idx];
   end

endmodule

/* source/insn_class_pkg.sv */
package insn_class_pkg;

   typedef logic [31:0] insn_word_t;
   typedef logic [6:0] opcode_t;
   typedef logic [4:0] reg_idx_t;

   localparam opcode_t OPC_BRANCH = 7'h63;
   localparam opcode_t OPC_JALR = 7'h67;
   localparam opcode_t OPC_JAL = 7'h6f;

   // control-flow class of one instruction
   typedef enum logic [2:0]
   {
      PD_NONE,
      PD_COND_BR,
      PD_J,
      PD_JAL,
      PD_JR,
      PD_JALR
   } pd_class_t;

   // one class per word, word 0 in the low bits
   typedef pd_class_t [l1i_geometry_pkg::WORDS_PER_LINE-1:0] pd_line_t;

   typedef enum logic [2:0]
   {
      FLUSH_CACHE,
      IDLE,
      ACTIVE,
      INJECT_RELOAD,
      RELOAD_TURNAROUND,
      WAIT_FOR_NOT_FULL
   } fetch_state_t;

endpackage

/* source/l1i_fetch.sv */
`timescale 1ns/10ps

module l1i_fetch
(
   input  logic clk,
   input  logic reset,
   input  logic restart_valid,
   input  l1i_geometry_pkg::addr_t restart_pc,
   output logic restart_ack,
   input  logic flush_req,
   output logic flush_complete,
   output insn_class_pkg::insn_word_t insn_data,
   output l1i_geometry_pkg::addr_t insn_pc,
   output l1i_geometry_pkg::addr_t insn_pred_target,
   output logic insn_pred_taken,
   output logic insn_valid,
   input  logic insn_ack,
   output logic mem_req_valid,
   output l1i_geometry_pkg::addr_t mem_req_addr,
   input  logic mem_rsp_valid,
   input  l1i_geometry_pkg::line_t mem_rsp_data
);
   import l1i_geometry_pkg::*;
   import insn_class_pkg::*;

   set_idx_t lookup_idx, inval_idx;
   tag_t rd_tag;
   line_t rd_line;
   pd_line_t rd_pd, fill_pd;
   insn_word_t push_data;
   addr_t push_pc, push_target;
   logic rd_valid, inval_valid, fq_full, fq_clear, fq_push, push_taken;

   fetch_control ctrl_i (.*);

   // the reload writes the line at the address still held on the request
   icache_arrays arrays_i
   (
      .rd_idx(lookup_idx),
      .fill_valid(mem_rsp_valid),
      .fill_addr(mem_req_addr),
      .fill_line(mem_rsp_data),
      .*
   );

   // predecode the returning line on its way into the arrays
   for (genvar i = 0; i < WORDS_PER_LINE; i++)
   begin : g_pd
      predecoder pd_i
      (
         .word(mem_rsp_data[i*32 +: 32]),
         .pd(fill_pd[i])
      );
   end

   fetch_queue queue_i
   (
      .clear(fq_clear),
      .push(fq_push),
      .pop(insn_ack),
      .full(fq_full),
      .head_valid(insn_valid),
      .head_data(insn_data),
      .head_pc(insn_pc),
      .head_target(insn_pred_target),
      .head_taken(insn_pred_taken),
      .*
   );

endmodule

/* source/l1i_geometry_pkg.sv */
package l1i_geometry_pkg;

   localparam int ADDR_WIDTH = 32;

   // 16 sets of 16-byte lines
   localparam int LG_NUM_SETS = 4;
   localparam int NUM_SETS = 1 << LG_NUM_SETS;
   localparam int LG_LINE_BYTES = 4;
   localparam int WORDS_PER_LINE = (1 << LG_LINE_BYTES) / 4;
   localparam int LINE_BITS = WORDS_PER_LINE * 32;

   // address bits above the set index
   localparam int TAG_BITS = ADDR_WIDTH - LG_NUM_SETS - LG_LINE_BYTES;

   localparam int LG_FQ_ENTRIES = 3;
   localparam int FQ_ENTRIES = 1 << LG_FQ_ENTRIES;

   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [LG_NUM_SETS-1:0] set_idx_t;
   typedef logic [TAG_BITS-1:0] tag_t;
   typedef logic [LINE_BITS-1:0] line_t;
   typedef logic [LG_LINE_BYTES-3:0] word_sel_t;

   // extra wrap bit tells full from empty
   typedef logic [LG_FQ_ENTRIES:0] fq_ptr_t;

endpackage

/* source/predecoder.sv */
`timescale 1ns/10ps

module predecoder
(
   input  insn_class_pkg::insn_word_t word,
   output insn_class_pkg::pd_class_t pd
);
   import insn_class_pkg::*;

   opcode_t opcode;
   reg_idx_t rd;

   assign opcode = word[6:0];
   assign rd = word[11:7];

   // rd of x0 means no link, so plain j / jr
   always_comb
   begin
      case (opcode)
         OPC_BRANCH:
            pd = PD_COND_BR;
         OPC_JALR:
            pd = (rd == '0) ? PD_JR : PD_JALR;
         OPC_JAL:
            pd = (rd == '0) ? PD_J : PD_JAL;
         default:
            pd = PD_NONE;
      endcase
   end

endmodule

/* testbench/fetch_trace.txt */
// kind addr data taken target, all hex
// kind 1 memory word, 2 restart, 3 expected entry, 4 flush, 5 line request count in data
1 00000100 00100093 0 0
1 00000104 00200093 0 0
1 00000108 00300093 0 0
1 0000010c 0200006f 0 0
1 0000012c 00400093 0 0
1 00000130 00500093 0 0
1 00000134 00600093 0 0
1 00000240 00700093 0 0
1 00000244 144000ef 0 0
1 00000388 00000463 0 0
1 0000038c 00008067 0 0
1 00000390 00800093 0 0
2 00000100 0 0 0
3 00000100 00100093 0 00000104
3 00000104 00200093 0 00000108
3 00000108 00300093 0 0000010c
3 0000010c 0200006f 1 0000012c
3 0000012c 00400093 0 00000130
3 00000130 00500093 0 00000134
3 00000134 00600093 0 00000138
2 00000240 0 0 0
3 00000240 00700093 0 00000244
3 00000244 144000ef 1 00000388
3 00000388 00000463 0 0000038c
3 0000038c 00008067 0 00000390
3 00000390 00800093 0 00000394
5 00000100 1 0 0
2 00000100 0 0 0
3 00000100 00100093 0 00000104
3 00000104 00200093 0 00000108
5 00000100 1 0 0
4 0 0 0 0
2 00000100 0 0 0
3 00000100 00100093 0 00000104
5 00000100 2 0 0

/* testbench/l1i_fetch_tb.sv */
`timescale 1ns/10ps

module l1i_fetch_tb;
   import l1i_geometry_pkg::*;
   import insn_class_pkg::*;

   logic clk;
   logic reset;
   logic restart_valid;
   addr_t restart_pc;
   logic restart_ack;
   logic flush_req;
   logic flush_complete;
   insn_word_t insn_data;
   addr_t insn_pc;
   addr_t insn_pred_target;
   logic insn_pred_taken;
   logic insn_valid;
   logic insn_ack;
   logic mem_req_valid;
   addr_t mem_req_addr;
   logic mem_rsp_valid;
   line_t mem_rsp_data;

   // five words per record: kind, address, data, taken, target
   logic [31:0] trace [0:511];
   insn_word_t mem_image [addr_t];
   int line_reqs [addr_t];
   int value_errors = 0;
   int protocol_errors = 0;
   int expects = 0;
   int flushes = 0;
   int restarts = 0;
   int flush_pulses = 0;
   int ack_pulses = 0;
   int cycle_limit = 0;
   logic started = 1'b0;

   l1i_fetch dut_i (.*);

   initial
   begin
      clk = 1'b0;
      forever
         #50 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("ERROR %s got %h expected %h", name, got, exp);
         value_errors++;
      end
   endtask

   // words outside the image decode as alu ops tagged with their address
   function automatic insn_word_t mem_word(input addr_t a);
      if (mem_image.exists(a))
         return mem_image[a];
      return ((a ^ (a >> 13)) << 7) | 32'h13;
   endfunction

   function automatic line_t build_line(input addr_t base);
      line_t line;
      for (int i = 0; i < WORDS_PER_LINE; i++)
         line[i*32 +: 32] = mem_word(base + i * 4);
      return line;
   endfunction

   // J-type immediate, sign extended
   function automatic addr_t jump_offset(input insn_word_t w);
      return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
   endfunction

   task automatic load_trace();
      for (int i = 0; i < $size(trace); i++)
         trace[i] = '0;
      $readmemh("testbench/fetch_trace.txt", trace);
      for (int r = 0; r * 5 < $size(trace) && trace[r*5] != 0; r++)
      begin
         if (trace[r*5] == 1)
            mem_image[trace[r*5+1]] = trace[r*5+2];
         else if (trace[r*5] == 3)
            expects++;
         else if (trace[r*5] == 4)
            flushes++;
      end
   endtask

   task automatic issue_restart(input addr_t target);
      restart_valid <= 1'b1;
      restart_pc <= target;
      insn_ack <= 1'b0;
      @(posedge clk);
      restart_valid <= 1'b0;
      @(posedge clk);
      while (!restart_ack)
         @(posedge clk);
   endtask

   task automatic run_flush();
      flush_req <= 1'b1;
      insn_ack <= 1'b0;
      @(posedge clk);
      flush_req <= 1'b0;
      @(posedge clk);
      while (!flush_complete)
         @(posedge clk);
   endtask

   // random ack gives back-pressure on the queue
   task automatic pop_entry(output addr_t pc, output insn_word_t data,
                            output logic taken, output addr_t target);
      logic popped;
      popped = 1'b0;
      while (!popped)
      begin
         @(posedge clk);
         if (insn_valid && insn_ack)
         begin
            popped = 1'b1;
            pc = insn_pc;
            data = insn_data;
            taken = insn_pred_taken;
            target = insn_pred_target;
         end
         insn_ack <= ($urandom % 4) != 0;
      end
   endtask

   always @(posedge clk)
   begin
      if (!reset)
      begin
         if (flush_complete)
            flush_pulses++;
         if (restart_ack)
            ack_pulses++;
         if (!started)
            assert (!insn_valid && !mem_req_valid)
            else
            begin
               $display("fetch activity seen before the first restart");
               protocol_errors++;
            end
      end
   end

   // memory answers one line request at a time
   initial
   begin
      addr_t req_addr;
      int delay;
      forever
      begin
         @(posedge clk);
         if (!reset && mem_req_valid)
         begin
            req_addr = mem_req_addr;
            check_value("mem_req_addr", req_addr,
                        {req_addr[ADDR_WIDTH-1:LG_LINE_BYTES], {LG_LINE_BYTES{1'b0}}});
            if (line_reqs.exists(req_addr))
               line_reqs[req_addr]++;
            else
               line_reqs[req_addr] = 1;
            delay = 1 + $urandom % 6;
            repeat (delay) @(posedge clk);
            mem_rsp_data <= build_line(req_addr);
            mem_rsp_valid <= 1'b1;
            @(posedge clk);
            mem_rsp_valid <= 1'b0;
         end
      end
   end

   initial
   begin
      wait (cycle_limit > 0);
      repeat (cycle_limit) @(posedge clk);
      $display("watchdog expired after %0d cycles before the trace was done", cycle_limit);
      $display("Some tests failed");
      $finish;
   end

   initial
   begin
      logic [31:0] kind, a, b, c, d;
      int reqs;
      addr_t got_pc, got_target, prev_target;
      insn_word_t got_data;
      logic got_taken, have_prev;
      void'($urandom(64242));
      reset = 1'b1;
      restart_valid = 1'b0;
      restart_pc = '0;
      flush_req = 1'b0;
      insn_ack = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp_data = '0;
      have_prev = 1'b0;
      prev_target = '0;
      load_trace();
      cycle_limit = expects * 200 + (flushes + 1) * (NUM_SETS + 2);
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      assert (!restart_ack && !flush_complete && !mem_req_valid && !insn_valid)
      else
      begin
         $display("outputs not low after reset");
         protocol_errors++;
      end
      // flush walk runs by itself after reset
      @(posedge clk);
      while (!flush_complete)
         @(posedge clk);
      for (int r = 0; r * 5 < $size(trace) && trace[r*5] != 0; r++)
      begin
         kind = trace[r*5];
         a = trace[r*5+1];
         b = trace[r*5+2];
         c = trace[r*5+3];
         d = trace[r*5+4];
         case (kind)
            1:
            begin
            end
            2:
            begin
               started = 1'b1;
               issue_restart(a);
               restarts++;
               have_prev = 1'b0;
            end
            3:
            begin
               pop_entry(got_pc, got_data, got_taken, got_target);
               check_value("insn_pc", got_pc, a);
               check_value("insn_data", got_data, b);
               check_value("insn_pred_taken", {31'b0, got_taken}, c);
               check_value("insn_pred_target", got_target, d);
               // j and jal go to pc plus the immediate, all else falls through
               if (c[0])
                  check_value("insn_pred_target", got_target, a + jump_offset(b));
               else
                  check_value("insn_pred_target", got_target, a + 32'd4);
               if (have_prev)
                  check_value("insn_pc", got_pc, prev_target);
               prev_target = d;
               have_prev = 1'b1;
            end
            4:
            begin
               run_flush();
               have_prev = 1'b0;
            end
            5:
            begin
               reqs = line_reqs.exists(a) ? line_reqs[a] : 0;
               check_value("mem_req_valid count", reqs, b);
            end
            default:
            begin
               $display("unknown record kind %0d in the trace", kind);
               protocol_errors++;
            end
         endcase
      end
      repeat (2) @(posedge clk);
      if (flush_pulses != flushes + 1)
      begin
         $display("flush_complete pulsed %0d times, %0d expected", flush_pulses, flushes + 1);
         protocol_errors++;
      end
      if (ack_pulses != restarts)
      begin
         $display("restart_ack pulsed %0d times, %0d expected", ack_pulses, restarts);
         protocol_errors++;
      end
      $display("value errors %0d, protocol errors %0d", value_errors, protocol_errors);
      if (value_errors == 0 && protocol_errors == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule
